// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int XLEN   = 32;                 // Register and data width
    localparam int REG_AW = 5;                  // Register address width

    // Major opcodes handled by this decoder
    typedef enum logic [6:0] {
        OP_IMM   = 7'b0010011,
        OP_R3    = 7'b0110011,
        OP_LD    = 7'b0000011,
        OP_ST    = 7'b0100011,
        OP_BR    = 7'b1100011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111
    } opcode_e;

    // Arithmetic, shared by OP_IMM and OP_R3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // Stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // Branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;   // Selects SUB and SRA

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm_11_0;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]        imm_11_5;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_4_0;
        opcode_e           opcode;
    } s_fmt_t;

    typedef struct packed {
        logic              imm_12;
        logic [5:0]        imm_10_5;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [3:0]        imm_4_1;
        logic              imm_11;
        opcode_e           opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]       imm_31_12;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
    } u_fmt_t;

    typedef struct packed {
        logic              imm_20;
        logic [9:0]        imm_10_1;
        logic              imm_11;
        logic [7:0]        imm_19_12;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
    } j_fmt_t;

    // One instruction word, six views
    typedef union packed {
        r_fmt_t          r;
        i_fmt_t          i;
        s_fmt_t          s;
        b_fmt_t          b;
        u_fmt_t          u;
        j_fmt_t          j;
        logic [XLEN-1:0] raw;
    } instr_u;

endpackage

`default_nettype wire

// ==== logic/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    import isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                              // Result is operand B, used by LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    typedef struct packed {
        logic      reg_write;
        logic      src_a_pc;                    // Operand A is the PC, not rs1
        logic      src_b_imm;                   // Operand B is the immediate, not rs2
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_unsigned;
        wb_sel_e   wb_sel;
        logic      jump;
        logic      branch;
        alu_op_e   alu_op;
        logic      illegal;
    } ctrl_t;

    // Decoder starting point, a bubble that writes nothing
    localparam ctrl_t CTRL_NOP = '{
        reg_write:     1'b0,
        src_a_pc:      1'b0,
        src_b_imm:     1'b0,
        mem_read:      1'b0,
        mem_write:     1'b0,
        mem_size:      MEM_BYTE,
        load_unsigned: 1'b0,
        wb_sel:        WB_ALU,
        jump:          1'b0,
        branch:        1'b0,
        alu_op:        ALU_ADD,
        illegal:       1'b0
    };

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd;
        logic [2:0]        funct3;              // Kept for branch compare and store lanes
        ctrl_t             ctrl;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== logic/control_unit.sv ====
`default_nettype none

module control_unit
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire instr_u instr,
    output ctrl_t       ctrl,
    output imm_fmt_e    imm_fmt
);

    logic [2:0] funct3;
    logic       f7_alt;

    assign funct3 = instr.r.funct3;
    assign f7_alt = (instr.r.funct7 == FUNCT7_ALT);

    // ALU operation shared by register and immediate arithmetic
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: arith_op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: arith_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl    = CTRL_NOP;
        imm_fmt = IMM_NONE;

        case (instr.r.opcode)
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = arith_op(funct3, f7_alt && (funct3 == F3_SRL_SRA));  // No SUBI
                imm_fmt        = IMM_I;
            end
            OP_R3: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op(funct3, f7_alt);
            end
            OP_LD: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_sel    = WB_MEM;
                imm_fmt        = IMM_I;
                case (funct3)
                    F3_LB:  ctrl.mem_size = MEM_BYTE;
                    F3_LH:  ctrl.mem_size = MEM_HALF;
                    F3_LW:  ctrl.mem_size = MEM_WORD;
                    F3_LBU: begin
                        ctrl.mem_size      = MEM_BYTE;
                        ctrl.load_unsigned = 1'b1;
                    end
                    F3_LHU: begin
                        ctrl.mem_size      = MEM_HALF;
                        ctrl.load_unsigned = 1'b1;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            OP_ST: begin
                ctrl.mem_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                imm_fmt        = IMM_S;
                case (funct3)
                    F3_SB:   ctrl.mem_size = MEM_BYTE;
                    F3_SH:   ctrl.mem_size = MEM_HALF;
                    F3_SW:   ctrl.mem_size = MEM_WORD;
                    default: ctrl.illegal  = 1'b1;
                endcase
            end
            OP_BR: begin
                ctrl.branch = 1'b1;
                imm_fmt     = IMM_B;
                // Compare op on rs1/rs2, target adder lives in EX
                case (funct3)
                    F3_BEQ, F3_BNE:   ctrl.alu_op  = ALU_SUB;
                    F3_BLT, F3_BGE:   ctrl.alu_op  = ALU_SLT;
                    F3_BLTU, F3_BGEU: ctrl.alu_op  = ALU_SLTU;
                    default:          ctrl.illegal = 1'b1;
                endcase
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                imm_fmt        = IMM_U;
            end
            OP_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                imm_fmt        = IMM_U;
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a_pc  = 1'b1;          // Target is PC + imm
                ctrl.src_b_imm = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = WB_PC4;        // Link address
                imm_fmt        = IMM_J;
            end
            OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;          // Target is rs1 + imm
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm_fmt        = IMM_I;
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // Flagged only, so make sure it leaves no architectural trace
        if (ctrl.illegal) begin
            ctrl.reg_write = 1'b0;
            ctrl.mem_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
`default_nettype none

module imm_gen
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire instr_u     instr,
    input  wire imm_fmt_e   imm_fmt,
    output logic [XLEN-1:0] imm
);

    always_comb begin
        case (imm_fmt)
            IMM_I: imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            IMM_S: imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            IMM_B: begin
                imm = {{19{instr.b.imm_12}},
                       instr.b.imm_12,
                       instr.b.imm_11,
                       instr.b.imm_10_5,
                       instr.b.imm_4_1,
                       1'b0};                   // Halfword aligned offset
            end
            IMM_U: imm = {instr.u.imm_31_12, 12'b0};
            IMM_J: begin
                imm = {{11{instr.j.imm_20}},
                       instr.j.imm_20,
                       instr.j.imm_19_12,
                       instr.j.imm_11,
                       instr.j.imm_10_1,
                       1'b0};
            end
            default: imm = '0;                  // R-type has no immediate
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file
    import isa_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [REG_AW-1:0] rs1_addr,
    input  wire logic [REG_AW-1:0] rs2_addr,
    input  wire logic              wr_en,
    input  wire logic [REG_AW-1:0] wr_addr,
    input  wire logic [XLEN-1:0]   wr_data,
    output logic      [XLEN-1:0]   rs1_data,
    output logic      [XLEN-1:0]   rs2_data
);

    logic [XLEN-1:0] regs [(2**REG_AW)-1:1];   // x0 has no storage

    // Combinational read with same-cycle write-back bypass
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        if (addr == '0)
            read_port = '0;
        else if (wr_en && (wr_addr == addr))
            read_port = wr_data;
        else
            read_port = regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 2**REG_AW; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

// ==== logic/id_ex_reg.sv ====
`default_nettype none

module id_ex_reg
    import ctrl_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   in_valid,
    output logic        in_ready,
    input  wire id_ex_t in_data,
    output logic        out_valid,
    input  wire logic   out_ready,
    output id_ex_t      out_data
);

    logic accept;

    // Slot is free when empty or being drained this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;              // Drops to 0 on a drain with no new input
    end

    always_ff @(posedge clk) begin
        if (accept)
            out_data <= in_data;                // Holds under back-pressure
    end

endmodule

`default_nettype wire

// ==== logic/decode_top.sv ====
`default_nettype none

module decode_top
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              in_valid,
    output logic                   in_ready,
    input  wire instr_u            in_instr,
    input  wire logic [XLEN-1:0]   in_pc,
    input  wire logic              wb_en,
    input  wire logic [REG_AW-1:0] wb_rd,
    input  wire logic [XLEN-1:0]   wb_data,
    output logic                   out_valid,
    input  wire logic              out_ready,
    output id_ex_t                 out_data
);

    ctrl_t           ctrl;
    imm_fmt_e        imm_fmt;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    id_ex_t          id_ex;

    control_unit u_ctrl (
        .instr   (in_instr),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm (
        .instr   (in_instr),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (in_instr.r.rs1),             // Same bit slots in every format
        .rs2_addr (in_instr.r.rs2),
        .wr_en    (wb_en),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign id_ex = '{
        pc:       in_pc,
        rs1_data: rs1_data,
        rs2_data: rs2_data,
        imm:      imm,
        rd:       in_instr.r.rd,
        funct3:   in_instr.r.funct3,
        ctrl:     ctrl
    };

    id_ex_reg u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (id_ex),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // Period 10
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;                        // Released just after the 4th edge
    end

endmodule

`default_nettype wire

// ==== bench/decode_asserts.sv ====
`default_nettype none

module decode_asserts
    import ctrl_pkg::*;
(
    input wire logic   clk,
    input wire logic   rst_n,
    input wire logic   in_ready,
    input wire logic   out_valid,
    input wire logic   out_ready,
    input wire id_ex_t out_data
);

    int fail_count = 0;                         // Failed assertion count

    // A stalled output keeps its item and its payload
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            $error("out_data or out_valid changed while stalled");
            fail_count++;
        end

    reset_clear: assert property (@(posedge clk)
        !rst_n |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            fail_count++;
        end

    // One-entry slot is free when empty or draining
    ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == (!out_valid || out_ready))
        else begin
            $error("in_ready does not follow out_valid and out_ready");
            fail_count++;
        end

endmodule

bind decode_top decode_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

`default_nettype wire

// ==== bench/tb_decode.sv ====
`default_nettype none

module tb_decode
    import isa_pkg::*, ctrl_pkg::*;
();

    localparam int N_RESET   = 16;
    localparam int N_CTRL    = 9 * 8 * 2;
    localparam int N_IMM     = 5 * 20;
    localparam int N_REGS    = 40 + 20 + 2;     // Plain, forwarded and x0 reads
    localparam int N_STREAM  = 100;
    localparam int N_ILLEGAL = 30;
    localparam int TOTAL     = N_RESET + N_CTRL + N_IMM + N_REGS + N_STREAM + N_ILLEGAL;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    instr_u      in_instr;
    logic [31:0] in_pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        out_valid;
    logic        out_ready;
    id_ex_t      out_data;

    integer      seed;
    integer      ready_seed;
    logic        rand_ready;
    logic        acc_prev;
    logic [31:0] next_pc;
    logic [31:0] shadow [32];                   // Mirror of the register file
    logic [31:0] view [32];
    logic [6:0]  op_list [9];
    id_ex_t      exp_q [$];
    id_ex_t      exp_item;
    int          errors;
    int          checked;
    int          n_tests;
    int          test_err_base;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .in_pc     (in_pc),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    function automatic alu_op_e arith_ref(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'd0:    op = alt ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = alt ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Expected ID/EX payload straight from the RV32I encoding
    function automatic id_ex_t ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                          input logic [31:0] regs [32]);
        id_ex_t     e;
        ctrl_t      c;
        logic [2:0] f3;
        logic       alt;
        f3  = w[14:12];
        alt = (w[31:25] == 7'b0100000);
        c   = '0;                               // ADD, byte size, ALU write-back
        e   = '0;
        case (w[6:0])
            OP_R3: begin
                c.reg_write = 1'b1;
                c.alu_op    = arith_ref(f3, alt);
            end
            OP_IMM: begin
                c.reg_write = 1'b1;
                c.src_b_imm = 1'b1;
                c.alu_op    = arith_ref(f3, alt && (f3 == 3'd5));
                e.imm       = {{20{w[31]}}, w[31:20]};
            end
            OP_LD: begin
                c.reg_write = 1'b1;
                c.src_b_imm = 1'b1;
                c.mem_read  = 1'b1;
                c.wb_sel    = WB_MEM;
                c.illegal   = (f3 == 3'd3) || (f3 > 3'd5);
                if (!c.illegal) begin
                    c.mem_size      = mem_size_e'(f3[1:0]);
                    c.load_unsigned = f3[2];
                end
                e.imm = {{20{w[31]}}, w[31:20]};
            end
            OP_ST: begin
                c.mem_write = 1'b1;
                c.src_b_imm = 1'b1;
                c.illegal   = (f3 > 3'd2);
                if (!c.illegal)
                    c.mem_size = mem_size_e'(f3[1:0]);
                e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OP_BR: begin
                c.branch  = 1'b1;
                c.illegal = (f3[2:1] == 2'b01);
                if (!c.illegal)
                    c.alu_op = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
                e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            OP_LUI: begin
                c.reg_write = 1'b1;
                c.src_b_imm = 1'b1;
                c.alu_op    = ALU_PASS_B;
                e.imm       = {w[31:12], 12'b0};
            end
            OP_AUIPC: begin
                c.reg_write = 1'b1;
                c.src_a_pc  = 1'b1;
                c.src_b_imm = 1'b1;
                e.imm       = {w[31:12], 12'b0};
            end
            OP_JAL: begin
                c.reg_write = 1'b1;
                c.src_a_pc  = 1'b1;
                c.src_b_imm = 1'b1;
                c.jump      = 1'b1;
                c.wb_sel    = WB_PC4;
                e.imm       = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OP_JALR: begin
                c.reg_write = 1'b1;
                c.src_b_imm = 1'b1;
                c.jump      = 1'b1;
                c.wb_sel    = WB_PC4;
                e.imm       = {{20{w[31]}}, w[31:20]};
            end
            default: c.illegal = 1'b1;
        endcase
        if (c.illegal) begin
            c.reg_write = 1'b0;
            c.mem_write = 1'b0;
        end
        e.pc       = pc;
        e.rs1_data = (w[19:15] == 5'd0) ? 32'd0 : regs[w[19:15]];
        e.rs2_data = (w[24:20] == 5'd0) ? 32'd0 : regs[w[24:20]];
        e.rd       = w[11:7];
        e.funct3   = f3;
        e.ctrl     = c;
        return e;
    endfunction

    function automatic logic [31:0] make_instr(input logic [6:0] op, input logic [2:0] f3,
                                               input logic [6:0] f7);
        logic [31:0] w;
        w         = $random(seed);
        w[6:0]    = op;
        w[14:12]  = f3;
        w[31:25]  = f7;
        return w;
    endfunction

    function automatic logic is_known(input logic [6:0] op);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 9; k++)
            if (op_list[k] == op)
                hit = 1'b1;
        return hit;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_payload(input id_ex_t exp, input id_ex_t act);
        check_word("out_data.pc", exp.pc, act.pc);
        check_word("out_data.rs1_data", exp.rs1_data, act.rs1_data);
        check_word("out_data.rs2_data", exp.rs2_data, act.rs2_data);
        check_word("out_data.imm", exp.imm, act.imm);
        check_word("out_data.rd", 32'(exp.rd), 32'(act.rd));
        check_word("out_data.funct3", 32'(exp.funct3), 32'(act.funct3));
        check_ctrl("out_data.ctrl", exp.ctrl, act.ctrl);
    endtask

    // Called just after an edge, returns just after the accepting edge
    task automatic send(input logic [31:0] w);
        in_valid     = 1'b1;
        in_instr.raw = w;
        in_pc        = next_pc;
        next_pc      = next_pc + 32'd4;
        @(posedge clk);
        while (!in_ready)
            @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_wb(input logic [31:0] w, input logic [4:0] rd, input logic [31:0] data);
        wb_en   = 1'b1;
        wb_rd   = rd;
        wb_data = data;
        send(w);
        wb_en = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
        wb_en   = 1'b1;
        wb_rd   = rd;
        wb_data = data;
        @(posedge clk);
        #1;
        wb_en = 1'b0;
    endtask

    task automatic end_test(input string name, input int n_instr);
        rand_ready = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        $display("%s: %0d items, %0d errors", name, n_instr, errors - test_err_base);
        test_err_base = errors;
        n_tests++;
    endtask

    // Record the expected payload of every accepted input
    always @(posedge clk) begin
        if (rst_n && acc_prev && !out_valid) begin
            $display("Output not valid in the cycle after an accepted input");
            errors++;
        end
        acc_prev = rst_n && in_valid && in_ready;
        if (rst_n && in_valid && in_ready) begin
            view = shadow;
            if (wb_en && wb_rd != 5'd0)
                view[wb_rd] = wb_data;          // Same-cycle write-back is forwarded
            exp_q.push_back(ref_decode(in_instr.raw, in_pc, view));
        end
        if (rst_n && wb_en && wb_rd != 5'd0)
            shadow[wb_rd] = wb_data;
    end

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output transfer with no matching input");
                errors++;
            end else begin
                exp_item = exp_q.pop_front();
                check_payload(exp_item, out_data);
                checked++;
            end
        end
    end

    initial begin
        ready_seed = 32'h15fe_b299;
        out_ready  = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = rand_ready ? 1'($random(ready_seed)) : 1'b1;
        end
    end

    initial begin
        repeat (TOTAL * 8 + 100) @(posedge clk);
        $display("Timeout, the tests did not finish within %0d cycles", TOTAL * 8 + 100);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [6:0] op;
        logic [31:0] w;
        seed          = 32'h15fe_b299;
        in_valid      = 1'b0;
        in_instr      = '0;
        in_pc         = '0;
        wb_en         = 1'b0;
        wb_rd         = '0;
        wb_data       = '0;
        rand_ready    = 1'b0;
        acc_prev      = 1'b0;
        next_pc       = 32'h0000_1000;
        errors        = 0;
        checked       = 0;
        n_tests       = 0;
        test_err_base = 0;
        op_list = '{OP_IMM, OP_R3, OP_LD, OP_ST, OP_BR, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR};
        for (int r = 0; r < 32; r++)
            shadow[r] = '0;

        @(posedge rst_n);
        check_word("out_valid", 32'd0, 32'(out_valid));
        for (int k = 0; k < N_RESET; k++) begin
            w = make_instr(OP_R3, 3'd0, 7'd0);
            w[19:15] = 5'(2 * k);
            w[24:20] = 5'(2 * k + 1);
            send(w);
        end
        end_test("reset", N_RESET);

        for (int o = 0; o < 9; o++)
            for (int f = 0; f < 8; f++)
                for (int a = 0; a < 2; a++)
                    send(make_instr(op_list[o], 3'(f), a ? FUNCT7_ALT : 7'd0));
        end_test("control", N_CTRL);

        foreach (op_list[o])
            if (op_list[o] inside {OP_IMM, OP_ST, OP_BR, OP_LUI, OP_JAL})
                repeat (20) send(make_instr(op_list[o], 3'($random(seed)), 7'($random(seed))));
        end_test("immediate", N_IMM);

        for (int r = 0; r < 32; r++)
            write_reg(5'(r), $random(seed));    // x0 write included
        repeat (40) send(make_instr(OP_R3, 3'($random(seed)), 7'd0));
        for (int k = 0; k < 20; k++) begin
            w = make_instr(OP_R3, 3'd0, 7'd0);
            send_wb(w, k[0] ? w[24:20] : w[19:15], $random(seed));
        end
        w = make_instr(OP_R3, 3'd0, 7'd0);
        w[24:15] = '0;
        write_reg(5'd0, 32'hffff_ffff);
        send(w);
        send_wb(w, 5'd0, 32'hdead_beef);
        end_test("registers", N_REGS);

        rand_ready = 1'b1;
        repeat (N_STREAM)
            send(make_instr(op_list[{$random(seed)} % 9], 3'($random(seed)),
                            7'($random(seed))));
        end_test("stream", N_STREAM);

        repeat (20) begin
            op = 7'($random(seed));
            while (is_known(op))
                op = 7'($random(seed));
            send(make_instr(op, 3'($random(seed)), 7'd0));
        end
        foreach (op_list[o]) begin
            for (int f = 0; f < 8; f++) begin
                if ((op_list[o] == OP_LD && (f == 3 || f > 5)) ||
                    (op_list[o] == OP_ST && f > 2) ||
                    (op_list[o] == OP_BR && (f == 2 || f == 3)))
                    send(make_instr(op_list[o], 3'(f), 7'd0));
            end
        end
        end_test("illegal", N_ILLEGAL);

        errors = errors + dut0.u_asserts.fail_count;
        $display("%0d tests, %0d checks, %0d errors", n_tests, checked, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/id_ex_reg.sv
logic/decode_top.sv
bench/clk_gen.sv
bench/decode_asserts.sv
bench/tb_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?=
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
